// File: rtl/ctl_macros.svh
`ifndef CTL_MACROS_SVH
`define CTL_MACROS_SVH

// Clock and serial bit timing
`define CTL_CLK_HZ          48000000
`define CTL_BIT_TICKS       (`CTL_CLK_HZ / 2000000)   // 24 cycles per bit at 2 Mbit/s

// Command bytes
`define CTL_CMD_SET_BASE    8'h40   // 0x40..0x5f set bit i
`define CTL_CMD_CLR_BASE    8'h60   // 0x60..0x7f clear bit i
`define CTL_CMD_POWEROFF    8'h2e   // "."
`define CTL_CMD_CR          8'h0d
`define CTL_CMD_LF          8'h0a

// Counter lengths and bit positions
`define CTL_POWEROFF_CYCLES 255
`define CTL_BIT_SCREEN      4       // Screen rail
`define CTL_BIT_BACKLIGHT   13      // Needs the screen rail
`define CTL_MSG_LEN         16      // "CTL0 " + 8 hex + count + CR LF

`endif

// File: rtl/ctl_pkg.sv
package ctl_pkg;

   // One byte on the serial link
   typedef logic [7:0] ctl_byte_t;

   // Peripheral control word, one bit per rail or strap
   typedef logic [31:0] ctl_word_t;

   // Status line counter, wraps after 15
   typedef logic [3:0] msg_count_t;

   // Decoded meaning of a received byte
   typedef enum logic [2:0] {
      cmd_set,        // 0x40..0x5f
      cmd_clear,      // 0x60..0x7f
      cmd_poweroff,   // "."
      cmd_report,     // CR or LF
      cmd_none        // Anything else
   } cmd_kind_e;

   // Serial shifter states, shared by rx and tx
   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } uart_state_e;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module uart_rx import ctl_pkg::*; (
   input  logic      clk48,
   input  logic      rst_n,
   input  logic      rx,
   output ctl_byte_t rx_data,
   output logic      rx_strobe
);

   localparam int TICK_W = $clog2(`CTL_BIT_TICKS);
   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`CTL_BIT_TICKS - 1);
   localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`CTL_BIT_TICKS / 2 - 1);

   uart_state_e       state;
   logic [1:0]        rx_sync;     // Two-flop synchronizer
   logic              rx_prev;     // For falling edge detect
   logic [TICK_W-1:0] tick;
   logic [2:0]        bit_idx;
   ctl_byte_t         shift_reg;

   // Line idles high
   always_ff @(posedge clk48) begin
      if (!rst_n) begin
         rx_sync <= 2'b11;
         rx_prev <= 1'b1;
      end else begin
         rx_sync <= {rx_sync[0], rx};
         rx_prev <= rx_sync[1];
      end
   end

   always_ff @(posedge clk48) begin
      if (!rst_n) begin
         state     <= st_idle;
         tick      <= '0;
         bit_idx   <= '0;
         rx_strobe <= 1'b0;
      end else begin
         rx_strobe <= 1'b0;   // Single-cycle pulse
         case (state)
            st_idle: begin
               tick <= '0;
               if (rx_prev && !rx_sync[1]) state <= st_start;   // Start bit edge
            end
            st_start: begin
               if (tick == TICK_HALF) begin
                  // Mid start bit, still low or it was a glitch
                  tick    <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync[1] ? st_idle : st_data;
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            st_data: begin
               if (tick == TICK_LAST) begin
                  tick      <= '0;
                  shift_reg <= {rx_sync[1], shift_reg[7:1]};   // LSB first
                  bit_idx   <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= st_stop;
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            st_stop: begin
               if (tick == TICK_LAST) begin
                  tick  <= '0;
                  state <= st_idle;
                  if (rx_sync[1]) begin   // Framing error drops the byte
                     rx_data   <= shift_reg;
                     rx_strobe <= 1'b1;
                  end
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module uart_tx import ctl_pkg::*; (
   input  logic      clk48,
   input  logic      rst_n,
   input  ctl_byte_t tx_data,
   input  logic      tx_send,
   output logic      tx_ready,
   output logic      tx
);

   localparam int TICK_W = $clog2(`CTL_BIT_TICKS);
   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`CTL_BIT_TICKS - 1);

   uart_state_e       state;
   logic [TICK_W-1:0] tick;      // Cycles within current bit
   logic [2:0]        bit_idx;
   ctl_byte_t         shift_reg; // Remaining data bits

   assign tx_ready = (state == st_idle);   // Drops the cycle after tx_send

   always_ff @(posedge clk48) begin
      if (!rst_n) begin
         state   <= st_idle;
         tick    <= '0;
         bit_idx <= '0;
         tx      <= 1'b1;   // Idle line
      end else begin
         case (state)
            st_idle: begin
               tick <= '0;
               if (tx_send) begin
                  shift_reg <= tx_data;
                  tx        <= 1'b0;   // Start bit
                  state     <= st_start;
               end
            end
            st_start: begin
               if (tick == TICK_LAST) begin
                  tick      <= '0;
                  bit_idx   <= '0;
                  tx        <= shift_reg[0];   // LSB first
                  shift_reg <= {1'b0, shift_reg[7:1]};
                  state     <= st_data;
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            st_data: begin
               if (tick == TICK_LAST) begin
                  tick    <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     tx    <= 1'b1;   // Stop bit
                     state <= st_stop;
                  end else begin
                     tx        <= shift_reg[0];
                     shift_reg <= {1'b0, shift_reg[7:1]};
                  end
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            st_stop: begin
               if (tick == TICK_LAST) begin
                  tick  <= '0;
                  state <= st_idle;   // Ready again after full stop bit
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

// File: rtl/ctl_command_decoder.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module ctl_command_decoder import ctl_pkg::*; (
   input  logic      clk48,
   input  logic      rst_n,
   input  ctl_byte_t rx_data,
   input  logic      rx_strobe,
   output ctl_word_t ctl_bits,
   output logic      report_req,
   output logic      poweroff_n,
   output logic      activity_led
);

   localparam logic [4:0] BIT_SCREEN    = 5'(`CTL_BIT_SCREEN);
   localparam logic [4:0] BIT_BACKLIGHT = 5'(`CTL_BIT_BACKLIGHT);

   cmd_kind_e  cmd_kind;
   logic [4:0] bit_idx;        // Target bit of set/clear
   logic [7:0] poweroff_cnt;   // Cycles of power-off left

   assign bit_idx = rx_data[4:0];

   // Top three bits pick the set and clear ranges
   always_comb begin
      if ((rx_data & 8'he0) == `CTL_CMD_SET_BASE) begin
         cmd_kind = cmd_set;
      end else if ((rx_data & 8'he0) == `CTL_CMD_CLR_BASE) begin
         cmd_kind = cmd_clear;
      end else if (rx_data == `CTL_CMD_POWEROFF) begin
         cmd_kind = cmd_poweroff;
      end else if (rx_data == `CTL_CMD_CR || rx_data == `CTL_CMD_LF) begin
         cmd_kind = cmd_report;
      end else begin
         cmd_kind = cmd_none;
      end
   end

   // Low while counter runs, 255 cycles from a load
   assign poweroff_n = (poweroff_cnt == 8'd0);

   always_ff @(posedge clk48) begin
      if (!rst_n) begin
         ctl_bits     <= '0;
         report_req   <= 1'b0;
         poweroff_cnt <= 8'd0;
         activity_led <= 1'b0;
      end else begin
         report_req <= 1'b0;
         if (poweroff_cnt != 8'd0) poweroff_cnt <= poweroff_cnt - 1'b1;
         if (rx_strobe) begin
            activity_led <= ~activity_led;   // Every byte, known or not
            case (cmd_kind)
               cmd_set: begin
                  // Backlight only with the screen rail up
                  if (bit_idx != BIT_BACKLIGHT || ctl_bits[BIT_SCREEN])
                     ctl_bits[bit_idx] <= 1'b1;
               end
               cmd_clear: begin
                  ctl_bits[bit_idx] <= 1'b0;
                  if (bit_idx == BIT_SCREEN) ctl_bits[BIT_BACKLIGHT] <= 1'b0;   // No backfeed
               end
               cmd_poweroff: poweroff_cnt <= 8'(`CTL_POWEROFF_CYCLES);   // Reload
               cmd_report:   report_req   <= 1'b1;
               default: ;
            endcase
         end
      end
   end

endmodule

// File: rtl/status_reporter.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module status_reporter import ctl_pkg::*; (
   input  logic      clk48,
   input  logic      rst_n,
   input  ctl_word_t ctl_bits,
   input  logic      report_req,
   input  logic      tx_ready,
   output ctl_byte_t tx_data,
   output logic      tx_send
);

   // Counter digit, CR and LF close the line
   localparam logic [3:0] IDX_COUNT = 4'(`CTL_MSG_LEN - 3);
   localparam logic [3:0] IDX_CR    = 4'(`CTL_MSG_LEN - 2);
   localparam logic [3:0] IDX_LF    = 4'(`CTL_MSG_LEN - 1);

   logic       busy;       // Line in progress
   logic [3:0] char_idx;   // Next character to hand over
   ctl_word_t  snapshot;   // Control word at request time
   msg_count_t msg_count;
   logic [2:0] nib_sel;
   logic [3:0] nibble;

   // Lower-case hex digit
   function automatic ctl_byte_t hex_char(input logic [3:0] n);
      ctl_byte_t c;
      if (n < 4'd10) c = 8'h30 + {4'h0, n};   // "0".."9"
      else           c = 8'h57 + {4'h0, n};   // "a".."f"
      return c;
   endfunction

   assign tx_send = rst_n && busy && tx_ready;   // Handover cycle outside reset

   // Chars 5..12 walk nibbles 7..0 with the MS nibble first
   assign nib_sel = 3'(4'd12 - char_idx);
   assign nibble  = snapshot[{nib_sel, 2'b00} +: 4];

   always_comb begin
      case (char_idx)
         4'd0:      tx_data = 8'h43;   // C
         4'd1:      tx_data = 8'h54;   // T
         4'd2:      tx_data = 8'h4c;   // L
         4'd3:      tx_data = 8'h30;   // 0
         4'd4:      tx_data = 8'h20;   // Space
         IDX_COUNT: tx_data = hex_char(msg_count);
         IDX_CR:    tx_data = `CTL_CMD_CR;
         IDX_LF:    tx_data = `CTL_CMD_LF;
         default:   tx_data = hex_char(nibble);
      endcase
   end

   always_ff @(posedge clk48) begin
      if (!rst_n) begin
         busy      <= 1'b1;   // Startup line
         char_idx  <= '0;
         snapshot  <= '0;
         msg_count <= '0;
      end else begin
         if (tx_send) begin
            char_idx <= char_idx + 1'b1;   // Wraps to 0 after LF
            if (char_idx == IDX_COUNT) msg_count <= msg_count + 1'b1;
            if (char_idx == IDX_LF)    busy      <= 1'b0;
         end
         // New request restarts the line while the byte on the wire finishes
         if (report_req) begin
            snapshot <= ctl_bits;
            char_idx <= '0;
            busy     <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/board_ctl_top.sv
`timescale 1ns/100ps

module board_ctl_top import ctl_pkg::*; (
   input  logic      clk48,
   input  logic      rst_n,
   input  logic      uart_rxd,     // Commands from host
   output logic      uart_txd,     // Status lines to host
   output ctl_word_t ctl_bits,     // Peripheral control bits
   output logic      poweroff_n,   // Main FPGA power-off request
   output logic      activity_led
);

   ctl_byte_t rx_data;
   logic      rx_strobe;
   logic      report_req;
   ctl_byte_t tx_data;
   logic      tx_send;
   logic      tx_ready;

   uart_rx u_rx (
      .clk48     (clk48),
      .rst_n     (rst_n),
      .rx        (uart_rxd),
      .rx_data   (rx_data),
      .rx_strobe (rx_strobe)
   );

   ctl_command_decoder u_decoder (
      .clk48        (clk48),
      .rst_n        (rst_n),
      .rx_data      (rx_data),
      .rx_strobe    (rx_strobe),
      .ctl_bits     (ctl_bits),
      .report_req   (report_req),
      .poweroff_n   (poweroff_n),
      .activity_led (activity_led)
   );

   // Snapshot comes from the decoder's live control word
   status_reporter u_reporter (
      .clk48      (clk48),
      .rst_n      (rst_n),
      .ctl_bits   (ctl_bits),
      .report_req (report_req),
      .tx_ready   (tx_ready),
      .tx_data    (tx_data),
      .tx_send    (tx_send)
   );

   uart_tx u_tx (
      .clk48    (clk48),
      .rst_n    (rst_n),
      .tx_data  (tx_data),
      .tx_send  (tx_send),
      .tx_ready (tx_ready),
      .tx       (uart_txd)
   );

endmodule

// File: sim/board_ctl_assert.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module board_ctl_assert import ctl_pkg::*; (
   input logic      clk48,
   input logic      rst_n,
   input logic      uart_txd,
   input ctl_word_t ctl_bits,
   input logic      poweroff_n,
   input logic      activity_led
);

   logic [8:0] low_run;   // Consecutive cycles with poweroff_n low

   always_ff @(posedge clk48) begin
      if (!rst_n || poweroff_n) low_run <= '0;
      else if (low_run != 9'h1ff) low_run <= low_run + 1'b1;   // Saturate
   end

   // Backlight never on without the screen rail
   a_interlock: assert property (@(posedge clk48) disable iff (!rst_n)
      ctl_bits[`CTL_BIT_SCREEN] || !ctl_bits[`CTL_BIT_BACKLIGHT])
      else $error("backlight enabled while screen rail is off");

   a_poweroff_len: assert property (@(posedge clk48) disable iff (!rst_n)
      low_run <= 9'(`CTL_POWEROFF_CYCLES))
      else $error("poweroff_n low for more than the pulse length");

   a_known: assert property (@(posedge clk48) disable iff (!rst_n)
      !$isunknown({uart_txd, ctl_bits, poweroff_n, activity_led}))
      else $error("unknown value on a top-level output");

endmodule

bind board_ctl_top board_ctl_assert u_assert (
   .clk48        (clk48),
   .rst_n        (rst_n),
   .uart_txd     (uart_txd),
   .ctl_bits     (ctl_bits),
   .poweroff_n   (poweroff_n),
   .activity_led (activity_led)
);

// File: sim/board_ctl_tb.sv
`timescale 1ns/100ps
`include "ctl_macros.svh"

module board_ctl_tb import ctl_pkg::*; ();

   localparam int N_DIRECTED  = 4;
   localparam int N_RANDOM    = 60;
   localparam int N_CMDS      = N_DIRECTED + N_RANDOM;
   localparam int BYTE_CYCLES = 11 * `CTL_BIT_TICKS;   // Frame plus one idle bit
   localparam int LINE_CYCLES = `CTL_MSG_LEN * 10 * `CTL_BIT_TICKS;
   // Worst case: every command a "." or a report, plus startup and quiet lines
   localparam int TIMEOUT_CYCLES =
      2 * (N_CMDS * (BYTE_CYCLES + `CTL_POWEROFF_CYCLES) + (N_CMDS + 2) * LINE_CYCLES);

   logic      clk48;
   logic      rst_n;
   logic      uart_rxd;
   logic      uart_txd;
   ctl_word_t ctl_bits;
   logic      poweroff_n;
   logic      activity_led;

   ctl_byte_t   tx_q [$];      // Bytes rebuilt from uart_txd
   ctl_word_t   exp_ctl;       // Model control word
   msg_count_t  exp_count;     // Model message counter
   logic [31:0] rng_state;
   int          bytes_sent;
   int          low_len;       // Length of last poweroff_n low run
   int          cycle_count;

   board_ctl_top dut0 (
      .clk48        (clk48),
      .rst_n        (rst_n),
      .uart_rxd     (uart_rxd),
      .uart_txd     (uart_txd),
      .ctl_bits     (ctl_bits),
      .poweroff_n   (poweroff_n),
      .activity_led (activity_led)
   );

   initial begin
      clk48 = 1'b0;
      forever #5 clk48 = ~clk48;   // 10 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_ctl(input ctl_word_t got, input ctl_word_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t: ctl_bits is %08h, expected %08h", $time, got, exp);
         $display("Simulation failed");
         $fatal(1, "ctl_bits mismatch");
      end
   endtask

   task automatic check_char(input ctl_byte_t got, input ctl_byte_t exp, input int pos);
      if (got !== exp) begin
         $display("ERROR at %0t: status char %0d is 0x%02h, expected 0x%02h",
                  $time, pos, got, exp);
         $display("Simulation failed");
         $fatal(1, "status line mismatch");
      end
   endtask

   task automatic check_led(input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t: activity_led is %b, expected %b", $time, got, exp);
         $display("Simulation failed");
         $fatal(1, "activity_led mismatch");
      end
   endtask

   task automatic check_pulse(input int got, input int exp);
      if (got != exp) begin
         $display("ERROR at %0t: poweroff_n low for %0d cycles, expected %0d",
                  $time, got, exp);
         $display("Simulation failed");
         $fatal(1, "power-off pulse length mismatch");
      end
   endtask

   // Weighted pick, often aimed at the screen and backlight bits
   function automatic ctl_byte_t pick_command(input logic [31:0] r);
      logic [4:0] idx;
      ctl_byte_t  c;
      idx = r[12] ? (r[13] ? 5'd4 : 5'd13) : r[20:16];
      case (r[3:0])
         4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: c = `CTL_CMD_SET_BASE + {3'b000, idx};
         4'd6, 4'd7, 4'd8, 4'd9, 4'd10:      c = `CTL_CMD_CLR_BASE + {3'b000, idx};
         4'd11:   c = `CTL_CMD_POWEROFF;
         4'd12:   c = `CTL_CMD_CR;
         4'd13:   c = `CTL_CMD_LF;
         default: c = 8'h21;   // Unknown byte
      endcase
      return c;
   endfunction

   // Set, clear and interlock rules
   task automatic apply_model(input ctl_byte_t b);
      int i;
      i = int'(b[4:0]);
      if (b >= `CTL_CMD_SET_BASE && b <= `CTL_CMD_SET_BASE + 8'd31) begin
         if (i != `CTL_BIT_BACKLIGHT || exp_ctl[`CTL_BIT_SCREEN]) exp_ctl[i] = 1'b1;
      end else if (b >= `CTL_CMD_CLR_BASE && b <= `CTL_CMD_CLR_BASE + 8'd31) begin
         exp_ctl[i] = 1'b0;
         if (i == `CTL_BIT_SCREEN) exp_ctl[`CTL_BIT_BACKLIGHT] = 1'b0;
      end
   endtask

   task automatic hold_bit(input logic v);
      uart_rxd <= v;
      repeat (`CTL_BIT_TICKS) @(posedge clk48);
   endtask

   task automatic drive_byte(input ctl_byte_t b);
      @(posedge clk48);
      hold_bit(1'b0);   // Start
      for (int i = 0; i < 8; i++) hold_bit(b[i]);   // LSB first
      hold_bit(1'b1);   // Stop
      hold_bit(1'b1);   // Idle gap
   endtask

   // Expected line from the model word and counter
   task automatic expect_line();
      ctl_byte_t exp_line [`CTL_MSG_LEN];
      string     prefix;
      string     hex;
      ctl_byte_t got;
      prefix = "CTL0 ";
      hex    = "0123456789abcdef";
      for (int k = 0; k < 5; k++) exp_line[k] = prefix[k];
      for (int k = 0; k < 8; k++) exp_line[5 + k] = hex[exp_ctl[31 - 4 * k -: 4]];
      exp_line[13] = hex[exp_count];
      exp_line[14] = 8'h0d;
      exp_line[15] = 8'h0a;
      for (int k = 0; k < `CTL_MSG_LEN; k++) begin
         while (tx_q.size() == 0) @(negedge clk48);
         got = tx_q.pop_front();
         check_char(got, exp_line[k], k);
      end
      exp_count = exp_count + 1'b1;   // Wraps after 15
   endtask

   task automatic send_and_check(input ctl_byte_t b);
      low_len = 0;
      drive_byte(b);
      bytes_sent++;
      apply_model(b);
      @(negedge clk48);
      check_ctl(ctl_bits, exp_ctl);
      check_led(activity_led, bytes_sent[0]);   // Parity of bytes so far
      if (b == `CTL_CMD_POWEROFF) begin
         while (poweroff_n !== 1'b1) @(negedge clk48);
         check_pulse(low_len, `CTL_POWEROFF_CYCLES);
      end
      if (b == `CTL_CMD_CR || b == `CTL_CMD_LF) expect_line();
   endtask

   // Serial monitor, samples uart_txd mid-bit
   initial begin : tx_monitor
      ctl_byte_t b;
      @(posedge rst_n);
      forever begin
         @(negedge clk48);
         if (uart_txd === 1'b0) begin
            repeat (`CTL_BIT_TICKS / 2) @(negedge clk48);   // Middle of start bit
            for (int i = 0; i < 8; i++) begin
               repeat (`CTL_BIT_TICKS) @(negedge clk48);
               b[i] = uart_txd;
            end
            repeat (`CTL_BIT_TICKS) @(negedge clk48);
            if (uart_txd !== 1'b1) begin
               $display("Stop bit on uart_txd was not high at %0t", $time);
               $display("Simulation failed");
               $fatal(1, "framing error on uart_txd");
            end
            tx_q.push_back(b);
         end
      end
   end

   // Low-run length of poweroff_n
   initial begin : pulse_meter
      logic was_high;
      was_high = 1'b1;
      forever begin
         @(negedge clk48);
         if (poweroff_n === 1'b0) low_len = was_high ? 1 : low_len + 1;
         was_high = (poweroff_n !== 1'b0);
      end
   end

   initial begin : watchdog
      cycle_count = 0;
      forever begin
         @(posedge clk48);
         cycle_count++;
         if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin : stimulus
      rst_n      = 1'b0;
      uart_rxd   = 1'b1;   // Idle line
      exp_ctl    = '0;
      exp_count  = '0;
      rng_state  = 32'd96;
      bytes_sent = 0;
      low_len    = 0;
      repeat (4) @(posedge clk48);
      rst_n <= 1'b1;
      expect_line();   // Startup report
      send_and_check(8'h4d);   // Backlight refused, screen off
      send_and_check(8'h44);
      send_and_check(8'h4d);
      send_and_check(8'h64);   // Drops both
      for (int n = 0; n < N_RANDOM; n++) begin
         rng_state = xorshift32(rng_state);
         send_and_check(pick_command(rng_state));
      end
      repeat (LINE_CYCLES) @(negedge clk48);   // Room for a stray line
      if (tx_q.size() != 0) begin
         $display("Unexpected bytes on uart_txd after the last command: %0d", tx_q.size());
         $display("Simulation failed");
         $fatal(1, "stray output");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

// File: list.f
+incdir+rtl
rtl/ctl_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/ctl_command_decoder.sv
rtl/status_reporter.sv
rtl/board_ctl_top.sv
sim/board_ctl_assert.sv
sim/board_ctl_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module board_ctl_tb -o board_ctl_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/board_ctl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
